// File: bench/wb_host_tb.sv
/*
 * testbench for the wishbone host bridge
 * master accesses to the local registers and through the
 * bridge to a slave memory model, checked by clocked assertions
 */
`timescale 1ns/1ps
`include "wbh_params.svh"

module wb_host_tb
   import wbh_pkg::*;
();

   localparam int MAX_CYCLES = 3000;   // ~60 accesses of <= 12 cycles, plus margin

   logic     wbm_clk_i;
   logic     wbm_rst_n;
   logic     wbm_cyc_i;
   logic     wbm_stb_i;
   logic     wbm_we_i;
   wb_addr_t wbm_adr_i;
   wb_data_t wbm_dat_i;
   wb_sel_t  wbm_sel_i;
   wb_data_t wbm_dat_o;
   logic     wbm_ack_o;
   logic     wbm_err_o;
   logic     wbs_cyc_o;
   logic     wbs_stb_o;
   logic     wbs_we_o;
   wb_addr_t wbs_adr_o;
   wb_data_t wbs_dat_o;
   wb_sel_t  wbs_sel_o;
   wb_data_t wbs_dat_i;
   logic     wbs_ack_i;
   logic     wbs_err_i;
   logic     wbd_int_rst_n_o;
   logic     bist_rst_n_o;
   wb_data_t cfg_clk_ctrl1_o;
   wb_data_t cfg_clk_ctrl2_o;

   // --------------------------------------------------
   // expected state
   // --------------------------------------------------
   wb_data_t reg_model [4];        // registers as last written
   logic     acc_open   = 1'b0;    // master access in progress
   logic     exp_local;
   logic     exp_err;
   logic     exp_we;
   wb_addr_t exp_adr;              // bank on top of master bits 23..0
   wb_data_t exp_dat;
   wb_sel_t  exp_sel;
   wb_data_t exp_rdata;
   int       stb_edges;            // rising edges with master stb seen
   int       resp_cnt;             // ack/err pulses in this access
   int       cyc_cnt    = 0;
   logic     slv_stb_q  = 1'b0;    // slave bus one edge back
   logic     slv_resp_q = 1'b0;
   wb_addr_t slv_adr_q;

   wb_host UUT (.*);

   wbs_slave_model u_slave (
      .wbm_clk_i (wbm_clk_i),
      .wbm_rst_n (wbm_rst_n),
      .wbs_cyc_i (wbs_cyc_o),
      .wbs_stb_i (wbs_stb_o),
      .wbs_we_i  (wbs_we_o),
      .wbs_adr_i (wbs_adr_o),
      .wbs_dat_i (wbs_dat_o),
      .wbs_sel_i (wbs_sel_o),
      .wbs_dat_o (wbs_dat_i),
      .wbs_ack_o (wbs_ack_i),
      .wbs_err_o (wbs_err_i)
   );

   initial
   begin
      wbm_clk_i = 1'b0;
      forever #2 wbm_clk_i = ~wbm_clk_i;   // 4 ns period
   end

   task automatic abort_run();
      begin
         $display("TEST FAILED");
         $fatal(1, "stopped at the first error");
      end
   endtask

   task automatic report_mismatch(input string sig, input logic [31:0] got,
                                  input logic [31:0] want);
      begin
         $display("[FAIL] t=%0t %s got %h expected %h", $time, sig, got, want);
         abort_run();
      end
   endtask

   always @(posedge wbm_clk_i)
   begin
      cyc_cnt++;
      if (cyc_cnt > MAX_CYCLES)
      begin
         $display("timeout, the run did not finish within %0d cycles", MAX_CYCLES);
         abort_run();
      end
   end

   // --------------------------------------------------
   // checks, sampled on the rising edge
   // --------------------------------------------------
   always @(posedge wbm_clk_i)
   begin
      if (!acc_open)
      begin
         // reset values and idle bus, outputs track the register model
         assert (!wbm_ack_o) else report_mismatch("wbm_ack_o", wbm_ack_o, 0);
         assert (!wbm_err_o) else report_mismatch("wbm_err_o", wbm_err_o, 0);
         assert (!wbs_cyc_o) else report_mismatch("wbs_cyc_o", wbs_cyc_o, 0);
         assert (!wbs_stb_o) else report_mismatch("wbs_stb_o", wbs_stb_o, 0);
         assert (wbd_int_rst_n_o == reg_model[REG_GLB_CTRL][0])
            else report_mismatch("wbd_int_rst_n_o", wbd_int_rst_n_o, reg_model[0][0]);
         assert (bist_rst_n_o == reg_model[REG_GLB_CTRL][1])
            else report_mismatch("bist_rst_n_o", bist_rst_n_o, reg_model[0][1]);
         assert (cfg_clk_ctrl1_o == reg_model[REG_CLK_CTRL1])
            else report_mismatch("cfg_clk_ctrl1_o", cfg_clk_ctrl1_o, reg_model[2]);
         assert (cfg_clk_ctrl2_o == reg_model[REG_CLK_CTRL2])
            else report_mismatch("cfg_clk_ctrl2_o", cfg_clk_ctrl2_o, reg_model[3]);
      end
      else
      begin
         if (wbm_ack_o || wbm_err_o)
         begin
            assert (resp_cnt == 0) else report_mismatch("wbm_ack_o/err pulses", resp_cnt + 1, 1);
            assert (wbm_err_o == exp_err) else report_mismatch("wbm_err_o", wbm_err_o, exp_err);
            assert (wbm_ack_o == !exp_err) else report_mismatch("wbm_ack_o", wbm_ack_o, !exp_err);
            if (exp_local)   // strobe seen at E0, E1, E2
               assert (stb_edges == 3) else report_mismatch("local ack edges", stb_edges, 3);
            if (wbm_ack_o && !exp_we)
               assert (wbm_dat_o == exp_rdata) else report_mismatch("wbm_dat_o", wbm_dat_o, exp_rdata);
            resp_cnt++;
         end
         if (exp_local)
            assert (!wbs_cyc_o) else report_mismatch("wbs_cyc_o", wbs_cyc_o, 0);
         if (wbs_stb_o)
         begin
            assert (wbs_cyc_o) else report_mismatch("wbs_cyc_o", wbs_cyc_o, 1);
            assert (wbs_adr_o == exp_adr) else report_mismatch("wbs_adr_o", wbs_adr_o, exp_adr);
            assert (wbs_dat_o == exp_dat) else report_mismatch("wbs_dat_o", wbs_dat_o, exp_dat);
            assert (wbs_sel_o == exp_sel) else report_mismatch("wbs_sel_o", wbs_sel_o, exp_sel);
            assert (wbs_we_o == exp_we) else report_mismatch("wbs_we_o", wbs_we_o, exp_we);
         end
         if (wbm_stb_i)
            stb_edges++;
      end
      // slave strobe held with a stable address until the response edge
      if (slv_stb_q && !slv_resp_q)
      begin
         assert (wbs_stb_o) else report_mismatch("wbs_stb_o", wbs_stb_o, 1);
         assert (wbs_adr_o == slv_adr_q) else report_mismatch("wbs_adr_o", wbs_adr_o, slv_adr_q);
      end
      if (slv_stb_q && slv_resp_q)
      begin
         assert (!wbs_stb_o) else report_mismatch("wbs_stb_o", wbs_stb_o, 0);
         assert (!wbs_cyc_o) else report_mismatch("wbs_cyc_o", wbs_cyc_o, 0);
      end
      slv_stb_q  = wbs_stb_o;
      slv_resp_q = wbs_ack_i | wbs_err_i;
      slv_adr_q  = wbs_adr_o;
   end

   // --------------------------------------------------
   // master tasks
   // --------------------------------------------------
   function automatic wb_addr_t local_addr(input reg_idx_e idx);
      local_addr = 32'h0080_0000 | (32'(idx) << `WBH_REG_LSB);   // bit 23 set
   endfunction

   function automatic wb_addr_t ext_addr();
      ext_addr = $urandom() & 32'hff3f_fffc;   // bits 23, 22 clear, word aligned
   endfunction

   // one classic cycle, held until ack or err, expectations set first
   task automatic run_access(input logic we, input wb_addr_t adr, input wb_data_t dat,
                             input wb_sel_t sel, input wb_data_t rd_exp);
      reg_idx_e idx;
      begin
         idx = reg_idx_e'(adr[`WBH_REG_LSB +: 2]);
         @(negedge wbm_clk_i);
         exp_local = adr[`WBH_LOCAL_BIT];
         exp_err   = !adr[`WBH_LOCAL_BIT] && adr[22];
         exp_we    = we;
         exp_dat   = dat;
         exp_sel   = sel;
         exp_rdata = rd_exp;
         exp_adr   = {reg_model[REG_BANK_SEL][`WBH_BANK_W-1:0], adr[`WBH_OFFS_W-1:0]};
         stb_edges = 0;
         resp_cnt  = 0;
         acc_open  = 1'b1;
         wbm_cyc_i = 1'b1;
         wbm_stb_i = 1'b1;
         wbm_we_i  = we;
         wbm_adr_i = adr;
         wbm_dat_i = dat;
         wbm_sel_i = sel;
         @(negedge wbm_clk_i);
         while (!(wbm_ack_o || wbm_err_o))
            @(negedge wbm_clk_i);
         @(negedge wbm_clk_i);   // stb still held on the edge that samples the response
         wbm_cyc_i = 1'b0;
         wbm_stb_i = 1'b0;
         wbm_we_i  = 1'b0;
         @(negedge wbm_clk_i);   // a restart from the held stb shows up after this
         if (we && exp_local)
         begin
            if (idx == REG_BANK_SEL)
               reg_model[idx] = {{(`WBH_DW-`WBH_BANK_W){1'b0}}, dat[`WBH_BANK_W-1:0]};
            else
               reg_model[idx] = dat;
         end
         acc_open = 1'b0;
      end
   endtask

   task automatic write_reg(input reg_idx_e idx, input wb_data_t d);
      run_access(1'b1, local_addr(idx), d, wb_sel_t'($urandom()), '0);   // sel ignored
   endtask

   task automatic read_reg(input reg_idx_e idx);
      run_access(1'b0, local_addr(idx), $urandom(), 4'hf, reg_model[idx]);
   endtask

   // --------------------------------------------------
   // stimulus
   // --------------------------------------------------
   initial
   begin
      wb_data_t d;
      wb_addr_t a;
      void'($urandom(32'h10c3));
      wbm_rst_n = 1'b1;
      wbm_cyc_i = 1'b0;
      wbm_stb_i = 1'b0;
      wbm_we_i  = 1'b0;
      wbm_adr_i = '0;
      wbm_dat_i = '0;
      wbm_sel_i = '0;
      for (int i = 0; i < 4; i++)
         reg_model[i] = '0;
      #1 wbm_rst_n = 1'b0;   // clean falling edge for the async reset
      repeat (16) @(posedge wbm_clk_i);
      @(negedge wbm_clk_i);
      wbm_rst_n = 1'b1;
      repeat (2) @(negedge wbm_clk_i);

      // local registers, three rounds over every index
      for (int r = 0; r < 3; r++)
         for (int i = 0; i < 4; i++)
         begin
            write_reg(reg_idx_e'(i), $urandom());
            read_reg(reg_idx_e'(i));
         end

      // forwarded writes with random byte enables
      for (int n = 0; n < 8; n++)
         run_access(1'b1, ext_addr(), $urandom(), wb_sel_t'($urandom()), '0);

      // full word write then read back, bank moved half way
      for (int n = 0; n < 10; n++)
      begin
         if (n == 5)
            write_reg(REG_BANK_SEL, $urandom());
         a = ext_addr();
         d = $urandom();
         run_access(1'b1, a, d, 4'hf, '0);
         run_access(1'b0, a, $urandom(), 4'hf, d);
      end

      // slave error window
      for (int n = 0; n < 4; n++)
         run_access(n % 2 == 0, ext_addr() | 32'h0040_0000, $urandom(), 4'hf, '0);

      repeat (4) @(negedge wbm_clk_i);   // idle gap, no stray response
      $display("TEST PASSED");
      $finish;
   end

endmodule

// File: bench/wbs_slave_model.sv
/*
 * wishbone classic slave model
 * 64 word memory on address bits 7..2, 0 to 5 random wait
 * states, answers with err when address bit 22 is set
 */
`timescale 1ns/1ps
`include "wbh_params.svh"

module wbs_slave_model
   import wbh_pkg::*;
(
   input  logic     wbm_clk_i,
   input  logic     wbm_rst_n,
   input  logic     wbs_cyc_i,
   input  logic     wbs_stb_i,
   input  logic     wbs_we_i,
   input  wb_addr_t wbs_adr_i,
   input  wb_data_t wbs_dat_i,
   input  wb_sel_t  wbs_sel_i,
   output wb_data_t wbs_dat_o,
   output logic     wbs_ack_o,
   output logic     wbs_err_o
);

   wb_data_t    mem [64];
   int unsigned wait_left;   // wait states still to insert
   logic        busy;        // wait count drawn for this cycle
   logic [5:0]  widx;

   assign widx = wbs_adr_i[7:2];   // word index

   initial
   begin
      for (int i = 0; i < 64; i++)
         mem[i] = 32'h5a00_0000 | (i << 2);   // byte address as fill
      wbs_dat_o = '0;
      wbs_ack_o = 1'b0;
      wbs_err_o = 1'b0;
      busy      = 1'b0;
      wait_left = 0;
   end

   // responses change on the falling edge, stable at the rising one
   always @(negedge wbm_clk_i)
   begin
      wbs_ack_o <= 1'b0;   // single cycle response
      wbs_err_o <= 1'b0;
      if (!wbm_rst_n)
         busy = 1'b0;
      else if (wbs_cyc_i && wbs_stb_i && !wbs_ack_o && !wbs_err_o)
      begin
         if (!busy)
         begin
            wait_left = $urandom_range(5, 0);
            busy      = 1'b1;
         end
         if (wait_left != 0)
            wait_left--;   // stall the bridge
         else
         begin
            busy = 1'b0;
            if (wbs_adr_i[22])
               wbs_err_o <= 1'b1;   // error window, no write
            else
            begin
               wbs_ack_o <= 1'b1;
               if (wbs_we_i)
               begin
                  for (int b = 0; b < `WBH_SEL_W; b++)
                     if (wbs_sel_i[b])
                        mem[widx][8*b +: 8] = wbs_dat_i[8*b +: 8];
               end
               else
                  wbs_dat_o <= mem[widx];
            end
         end
      end
   end

endmodule

// File: design/host_reg_bank.sv
/*
 * host control registers
 * global control, bank select and two clock control words,
 * written by index and read back through a registered mux
 */
`timescale 1ns/1ps
`include "wbh_params.svh"

module host_reg_bank
   import wbh_pkg::*;
(
   input  logic     wbm_clk_i,
   input  logic     wbm_rst_n,

   input  logic     wr_en_i,    // one cycle write strobe
   input  logic     rd_en_i,    // one cycle read strobe
   input  reg_idx_e idx_i,
   input  wb_data_t wdata_i,
   output wb_data_t rdata_o,    // valid after the rd_en_i edge

   output bank_t    bank_sel_o,
   output logic     wbd_int_rst_n_o,
   output logic     bist_rst_n_o,
   output wb_data_t cfg_clk_ctrl1_o,
   output wb_data_t cfg_clk_ctrl2_o
);

   wb_data_t glb_ctrl_q;   // bit0 int reset, bit1 bist reset
   wb_data_t rd_mux;

   // --------------------------------------------------
   // write decode
   // --------------------------------------------------
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         glb_ctrl_q      <= '0;   // holds both resets asserted
         bank_sel_o      <= '0;
         cfg_clk_ctrl1_o <= '0;
         cfg_clk_ctrl2_o <= '0;
      end
      else if (wr_en_i)
      begin
         // whole word written, byte enables not used here
         case (idx_i)
            REG_GLB_CTRL:  glb_ctrl_q      <= wdata_i;
            REG_BANK_SEL:  bank_sel_o      <= wdata_i[`WBH_BANK_W-1:0];
            REG_CLK_CTRL1: cfg_clk_ctrl1_o <= wdata_i;
            REG_CLK_CTRL2: cfg_clk_ctrl2_o <= wdata_i;
            default:       glb_ctrl_q      <= glb_ctrl_q;
         endcase
      end
   end

   // --------------------------------------------------
   // read path
   // --------------------------------------------------
   always_comb
   begin
      case (idx_i)
         REG_GLB_CTRL:  rd_mux = glb_ctrl_q;
         REG_BANK_SEL:  rd_mux = {{(`WBH_DW-`WBH_BANK_W){1'b0}}, bank_sel_o};
         REG_CLK_CTRL1: rd_mux = cfg_clk_ctrl1_o;
         REG_CLK_CTRL2: rd_mux = cfg_clk_ctrl2_o;
         default:       rd_mux = '0;
      endcase
   end

   always_ff @(posedge wbm_clk_i)
   begin
      if (rd_en_i)
         rdata_o <= rd_mux;   // held until the next read
   end

   // reset controls for the user block
   assign wbd_int_rst_n_o = glb_ctrl_q[0];
   assign bist_rst_n_o    = glb_ctrl_q[1];

endmodule

// File: design/wb_host.sv
/*
 * wishbone host bridge, top level
 * master accesses with address bit 23 set hit the local control
 * registers, all others go out on the slave port with the bank
 * select as upper address byte
 */
`timescale 1ns/1ps
`include "wbh_params.svh"

module wb_host
   import wbh_pkg::*;
(
   input  logic     wbm_clk_i,
   input  logic     wbm_rst_n,

   // master port
   input  logic     wbm_cyc_i,
   input  logic     wbm_stb_i,
   input  logic     wbm_we_i,
   input  wb_addr_t wbm_adr_i,
   input  wb_data_t wbm_dat_i,
   input  wb_sel_t  wbm_sel_i,
   output wb_data_t wbm_dat_o,
   output logic     wbm_ack_o,
   output logic     wbm_err_o,

   // slave port
   output logic     wbs_cyc_o,
   output logic     wbs_stb_o,
   output logic     wbs_we_o,
   output wb_addr_t wbs_adr_o,
   output wb_data_t wbs_dat_o,
   output wb_sel_t  wbs_sel_o,
   input  wb_data_t wbs_dat_i,
   input  logic     wbs_ack_i,
   input  logic     wbs_err_i,

   // control outputs
   output logic     wbd_int_rst_n_o,
   output logic     bist_rst_n_o,
   output wb_data_t cfg_clk_ctrl1_o,
   output wb_data_t cfg_clk_ctrl2_o
);

   // --------------------------------------------------
   // internal nets
   // --------------------------------------------------
   logic                   reg_wr;      // bank write pulse
   logic                   reg_rd;      // bank read pulse
   reg_idx_e               reg_idx;
   wb_data_t               req_dat;     // captured write data
   wb_data_t               reg_rdata;
   logic                   ext_start;   // slave cycle kick
   logic [`WBH_OFFS_W-1:0] req_offs;
   logic                   req_we;
   wb_sel_t                req_sel;
   logic                   ext_done;
   logic                   ext_err;
   wb_data_t               ext_rdata;
   bank_t                  bank_sel;    // bank reg straight to bridge

   wb_host_ctrl u_ctrl (
      .wbm_clk_i   (wbm_clk_i),
      .wbm_rst_n   (wbm_rst_n),
      .wbm_cyc_i   (wbm_cyc_i),
      .wbm_stb_i   (wbm_stb_i),
      .wbm_we_i    (wbm_we_i),
      .wbm_adr_i   (wbm_adr_i),
      .wbm_dat_i   (wbm_dat_i),
      .wbm_sel_i   (wbm_sel_i),
      .wbm_dat_o   (wbm_dat_o),
      .wbm_ack_o   (wbm_ack_o),
      .wbm_err_o   (wbm_err_o),
      .reg_wr_o    (reg_wr),
      .reg_rd_o    (reg_rd),
      .reg_idx_o   (reg_idx),
      .req_dat_o   (req_dat),
      .reg_rdata_i (reg_rdata),
      .ext_start_o (ext_start),
      .req_offs_o  (req_offs),
      .req_we_o    (req_we),
      .req_sel_o   (req_sel),
      .ext_done_i  (ext_done),
      .ext_err_i   (ext_err),
      .ext_rdata_i (ext_rdata)
   );

   host_reg_bank u_regs (
      .wbm_clk_i       (wbm_clk_i),
      .wbm_rst_n       (wbm_rst_n),
      .wr_en_i         (reg_wr),
      .rd_en_i         (reg_rd),
      .idx_i           (reg_idx),
      .wdata_i         (req_dat),
      .rdata_o         (reg_rdata),
      .bank_sel_o      (bank_sel),
      .wbd_int_rst_n_o (wbd_int_rst_n_o),
      .bist_rst_n_o    (bist_rst_n_o),
      .cfg_clk_ctrl1_o (cfg_clk_ctrl1_o),
      .cfg_clk_ctrl2_o (cfg_clk_ctrl2_o)
   );

   wbs_bridge u_bridge (
      .wbm_clk_i  (wbm_clk_i),
      .wbm_rst_n  (wbm_rst_n),
      .start_i    (ext_start),
      .offs_i     (req_offs),
      .we_i       (req_we),
      .dat_i      (req_dat),
      .sel_i      (req_sel),
      .bank_sel_i (bank_sel),
      .wbs_cyc_o  (wbs_cyc_o),
      .wbs_stb_o  (wbs_stb_o),
      .wbs_we_o   (wbs_we_o),
      .wbs_adr_o  (wbs_adr_o),
      .wbs_dat_o  (wbs_dat_o),
      .wbs_sel_o  (wbs_sel_o),
      .wbs_dat_i  (wbs_dat_i),
      .wbs_ack_i  (wbs_ack_i),
      .wbs_err_i  (wbs_err_i),
      .done_o     (ext_done),
      .err_o      (ext_err),
      .rdata_o    (ext_rdata)
   );

endmodule

// File: design/wb_host_ctrl.sv
/*
 * wishbone host controller
 * takes one master access at a time, decodes local register
 * space against external space, pulses the register bank or
 * the slave bridge and registers ack, err and data back
 */
`timescale 1ns/1ps
`include "wbh_params.svh"

module wb_host_ctrl
   import wbh_pkg::*;
(
   input  logic                   wbm_clk_i,
   input  logic                   wbm_rst_n,

   // master port
   input  logic                   wbm_cyc_i,
   input  logic                   wbm_stb_i,
   input  logic                   wbm_we_i,
   input  wb_addr_t               wbm_adr_i,
   input  wb_data_t               wbm_dat_i,
   input  wb_sel_t                wbm_sel_i,
   output wb_data_t               wbm_dat_o,   // last read word
   output logic                   wbm_ack_o,
   output logic                   wbm_err_o,

   // register bank side
   output logic                   reg_wr_o,
   output logic                   reg_rd_o,
   output reg_idx_e               reg_idx_o,
   output wb_data_t               req_dat_o,
   input  wb_data_t               reg_rdata_i,

   // slave bridge side
   output logic                   ext_start_o,
   output logic [`WBH_OFFS_W-1:0] req_offs_o,
   output logic                   req_we_o,
   output wb_sel_t                req_sel_o,
   input  logic                   ext_done_i,
   input  logic                   ext_err_i,
   input  wb_data_t               ext_rdata_i
);

   host_state_e state_q;
   logic        req_start;   // accepted master request
   logic        req_local;   // hits local register space

   // a response still on the bus blocks the held strobe
   assign req_start = (state_q == IDLE) & wbm_cyc_i & wbm_stb_i
                      & ~wbm_ack_o & ~wbm_err_o;
   assign req_local = wbm_adr_i[`WBH_LOCAL_BIT];

   // --------------------------------------------------
   // request capture
   // --------------------------------------------------
   always_ff @(posedge wbm_clk_i)
   begin
      if (req_start)
      begin
         reg_idx_o  <= reg_idx_e'(wbm_adr_i[`WBH_REG_LSB +: $bits(reg_idx_e)]);
         req_dat_o  <= wbm_dat_i;
         req_offs_o <= wbm_adr_i[`WBH_OFFS_W-1:0];   // bank added by bridge
         req_we_o   <= wbm_we_i;
         req_sel_o  <= wbm_sel_i;   // local writes do not look at it
      end
   end

   // --------------------------------------------------
   // FSM and response
   // --------------------------------------------------
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         state_q     <= IDLE;
         reg_wr_o    <= 1'b0;
         reg_rd_o    <= 1'b0;
         ext_start_o <= 1'b0;
         wbm_ack_o   <= 1'b0;
         wbm_err_o   <= 1'b0;
         wbm_dat_o   <= '0;
      end
      else
      begin
         // all pulses one cycle wide
         reg_wr_o    <= 1'b0;
         reg_rd_o    <= 1'b0;
         ext_start_o <= 1'b0;
         wbm_ack_o   <= 1'b0;
         wbm_err_o   <= 1'b0;

         case (state_q)
            IDLE:
            begin
               if (req_start)
               begin
                  if (req_local)
                  begin
                     state_q  <= LOCAL;
                     reg_wr_o <= wbm_we_i;    // bank acts on next edge
                     reg_rd_o <= ~wbm_we_i;
                  end
                  else
                  begin
                     state_q     <= EXT_WAIT;
                     ext_start_o <= 1'b1;     // slave cyc up next edge
                  end
               end
            end

            LOCAL: state_q <= RESP;   // bank write / read capture

            RESP:
            begin
               // read data from the bank is settled here
               state_q   <= IDLE;
               wbm_ack_o <= 1'b1;
               if (!req_we_o)
                  wbm_dat_o <= reg_rdata_i;
            end

            EXT_WAIT:
            begin
               // no timeout, slave may stall forever
               if (ext_done_i)
               begin
                  state_q   <= IDLE;
                  wbm_ack_o <= ~ext_err_i;   // ack and err exclusive
                  wbm_err_o <= ext_err_i;
                  if (!req_we_o && !ext_err_i)
                     wbm_dat_o <= ext_rdata_i;
               end
            end

            default: state_q <= IDLE;
         endcase
      end
   end

endmodule

// File: design/wbh_pkg.sv
/*
 * wishbone host bridge types
 * bus word types, controller states and register indices
 */
`include "wbh_params.svh"

package wbh_pkg;

   // --------------------------------------------------
   // bus types
   // --------------------------------------------------
   typedef logic [`WBH_DW-1:0]     wb_data_t;   // data word
   typedef logic [`WBH_AW-1:0]     wb_addr_t;   // byte address
   typedef logic [`WBH_SEL_W-1:0]  wb_sel_t;    // byte enables
   typedef logic [`WBH_BANK_W-1:0] bank_t;      // upper address bank

   // --------------------------------------------------
   // controller FSM
   // --------------------------------------------------
   typedef enum logic [1:0]
   {
      IDLE     = 2'd0,   // waiting for a master strobe
      LOCAL    = 2'd1,   // register bank access
      EXT_WAIT = 2'd2,   // slave cycle in flight
      RESP     = 2'd3    // local ack, strobe ignored
   } host_state_e;

   // local register index, address bits 3..2
   typedef enum logic [1:0]
   {
      REG_GLB_CTRL  = 2'd0,
      REG_BANK_SEL  = 2'd1,
      REG_CLK_CTRL1 = 2'd2,
      REG_CLK_CTRL2 = 2'd3
   } reg_idx_e;

endpackage

// File: design/wbs_bridge.sv
/*
 * slave side wishbone classic master
 * runs one cycle per start pulse with the bank select on top of
 * the 24 bit offset, holds the strobe until ack or err
 */
`timescale 1ns/1ps
`include "wbh_params.svh"

module wbs_bridge
   import wbh_pkg::*;
(
   input  logic                   wbm_clk_i,
   input  logic                   wbm_rst_n,

   // request from the controller
   input  logic                   start_i,
   input  logic [`WBH_OFFS_W-1:0] offs_i,
   input  logic                   we_i,
   input  wb_data_t               dat_i,
   input  wb_sel_t                sel_i,
   input  bank_t                  bank_sel_i,

   // slave port
   output logic                   wbs_cyc_o,
   output logic                   wbs_stb_o,
   output logic                   wbs_we_o,
   output wb_addr_t               wbs_adr_o,
   output wb_data_t               wbs_dat_o,
   output wb_sel_t                wbs_sel_o,
   input  wb_data_t               wbs_dat_i,
   input  logic                   wbs_ack_i,
   input  logic                   wbs_err_i,

   // completion back to the controller
   output logic                   done_o,
   output logic                   err_o,
   output wb_data_t               rdata_o
);

   logic slv_resp;   // slave answered this cycle

   assign slv_resp = wbs_stb_o & (wbs_ack_i | wbs_err_i);

   // --------------------------------------------------
   // cycle control
   // --------------------------------------------------
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         wbs_cyc_o <= 1'b0;
         wbs_stb_o <= 1'b0;
         done_o    <= 1'b0;
         err_o     <= 1'b0;
      end
      else
      begin
         done_o <= 1'b0;
         if (start_i)
         begin
            wbs_cyc_o <= 1'b1;   // cyc and stb together
            wbs_stb_o <= 1'b1;
         end
         else if (slv_resp)
         begin
            wbs_cyc_o <= 1'b0;   // drop on the response edge
            wbs_stb_o <= 1'b0;
            done_o    <= 1'b1;
            err_o     <= wbs_err_i;
         end
      end
   end

   // --------------------------------------------------
   // request and read data
   // --------------------------------------------------
   always_ff @(posedge wbm_clk_i)
   begin
      if (start_i)
      begin
         wbs_adr_o <= {bank_sel_i, offs_i};   // indirect upper byte
         wbs_we_o  <= we_i;
         wbs_dat_o <= dat_i;
         wbs_sel_o <= sel_i;
      end
      if (slv_resp)
         rdata_o <= wbs_dat_i;
   end

endmodule

// File: filelist.f
+incdir+include
design/wbh_pkg.sv
design/host_reg_bank.sv
design/wbs_bridge.sv
design/wb_host_ctrl.sv
design/wb_host.sv
bench/wbs_slave_model.sv
bench/wb_host_tb.sv

// File: include/wbh_params.svh
/*
 * wishbone host bridge parameters
 * bus widths and the local address map
 */
`ifndef WBH_PARAMS_SVH
`define WBH_PARAMS_SVH

// --------------------------------------------------
// bus widths
// --------------------------------------------------
`define WBH_DW        32   // data word
`define WBH_AW        32   // full address
`define WBH_SEL_W     4    // one enable per byte
`define WBH_BANK_W    8    // upper address bits from bank reg
`define WBH_OFFS_W    24   // master bits passed through

// --------------------------------------------------
// address map
// --------------------------------------------------
// bit 23 set selects the host's own registers,
// everything else goes out on the slave port
`define WBH_LOCAL_BIT 23
`define WBH_REG_LSB   2    // word aligned register index

`endif
